// ==== Makefile ====
# Verilator build and run for the UMI width adapter testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_umi_width_adapter
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/umi_beat_fifo.sv ====
//########################################
// Synchronous beat FIFO for the width
// adapter. Holds output beats, reports
// full and empty, and can be bypassed so
// beats pass straight to the outputs.
//########################################

module umi_beat_fifo
  (
   input  logic                    umi_in_clk,
   input  logic                    umi_in_nreset,
   input  logic                    bypass,
   // Write side
   input  umi_flex_pkg::umi_beat_t beat,
   input  logic                    beat_valid,
   output logic                    beat_ready,
   // Read side
   output umi_flex_pkg::umi_beat_t out_beat,
   output logic                    out_valid,
   input  logic                    out_ready,
   // Status
   output logic                    fifo_full,
   output logic                    fifo_empty
   );

   import umi_flex_pkg::*;

   umi_beat_t mem [fifo_depth];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_cnt_t count;
   logic      full_raw;
   logic      empty_raw;
   logic      wr_en;
   logic      rd_en;

   // Two flops after reset release
   logic [1:0] release_q;
   logic       out_of_reset;

   //########################################
   // Reset release delay
   //########################################
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         release_q <= 2'b00;
      end
      else
      begin
         release_q <= {release_q[0], 1'b1};
      end
   end

   assign out_of_reset = release_q[1];

   //########################################
   // Storage
   //########################################
   assign full_raw  = (count == fifo_cnt_t'(fifo_depth));
   assign empty_raw = (count == '0);

   assign wr_en = ~bypass & out_of_reset & beat_valid & ~full_raw;
   assign rd_en = ~bypass & out_of_reset & out_ready & ~empty_raw;

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(1);
         end
         if (rd_en)
         begin
            rd_ptr <= rd_ptr + fifo_ptr_t'(1);
         end
         // Simultaneous push and pop leaves count alone
         case ({wr_en, rd_en})
            2'b10:   count <= count + fifo_cnt_t'(1);
            2'b01:   count <= count - fifo_cnt_t'(1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= beat;
      end
   end

   //########################################
   // Bypass and outputs
   //########################################
   assign beat_ready = out_of_reset & (bypass ? out_ready : ~full_raw);
   assign out_valid  = out_of_reset & (bypass ? beat_valid : ~empty_raw);
   assign out_beat   = bypass ? beat : mem[rd_ptr];

   assign fifo_full  = bypass ? ~out_ready : full_raw;
   assign fifo_empty = bypass | empty_raw;

endmodule

// ==== design/umi_cmd_decode.sv ====
//########################################
// Command decode for the width adapter.
// Unpacks the current command word and
// sizes this beat against the output bus.
// Purely combinational.
//########################################

module umi_cmd_decode
  (
   input  umi_flex_pkg::umi_cmd_word_t cur_cmd,
   output umi_flex_pkg::umi_cmd_t      cmd,
   output umi_flex_pkg::umi_len_t      beat_len,
   output umi_flex_pkg::umi_len_t      rest_len,
   output logic                        needs_split
   );

   import umi_flex_pkg::*;

   // Units in flight and units per output beat
   logic [8:0] len_plus_one;
   logic [8:0] capacity;

   //########################################
   // Field unpack
   //########################################
   always_comb
   begin
      cmd.opcode = cur_cmd[cmd_opcode_hi:cmd_opcode_lo];
      cmd.size   = cur_cmd[cmd_size_hi:cmd_size_lo];
      cmd.len    = cur_cmd[cmd_len_hi:cmd_len_lo];
      cmd.qos    = cur_cmd[cmd_qos_hi:cmd_qos_lo];
      cmd.prot   = cur_cmd[cmd_prot_hi:cmd_prot_lo];
      cmd.eom    = cur_cmd[cmd_eom_bit];
      cmd.eof    = cur_cmd[cmd_eof_bit];
      cmd.ex     = cur_cmd[cmd_ex_bit];
      cmd.user   = cur_cmd[cmd_user_hi:cmd_user_lo];
      cmd.hostid = cur_cmd[cmd_hostid_hi:cmd_hostid_lo];
   end

   //########################################
   // Beat sizing
   //########################################
   assign len_plus_one = {1'b0, cmd.len} + 9'd1;

   // SIZE above 3 leaves this at zero and the output undefined
   assign capacity = 9'(odw_bytes) >> cmd.size;

   assign needs_split = (len_plus_one > capacity);

   // Full beat when splitting, else the command as is
   assign beat_len = needs_split ? umi_len_t'(capacity - 9'd1) : cmd.len;

   // Only meaningful when needs_split is high
   assign rest_len = cmd.len - umi_len_t'(capacity);

endmodule

// ==== design/umi_flex_pkg.sv ====
//########################################
// Shared widths, command field positions
// and types for the UMI width adapter.
// Every design file imports this package
// inside its module body.
//########################################

package umi_flex_pkg;

   //########################################
   // Widths
   //########################################
   localparam int umi_cw     = 32;
   localparam int umi_aw     = 64;
   localparam int umi_idw    = 128;
   localparam int umi_odw    = 64;
   localparam int odw_bytes  = umi_odw / 8;
   localparam int fifo_depth = 4;
   localparam int fifo_aw    = $clog2(fifo_depth);

   // Command word bit positions
   localparam int cmd_opcode_lo = 0;
   localparam int cmd_opcode_hi = 4;
   localparam int cmd_size_lo   = 5;
   localparam int cmd_size_hi   = 7;
   localparam int cmd_len_lo    = 8;
   localparam int cmd_len_hi    = 15;
   localparam int cmd_qos_lo    = 16;
   localparam int cmd_qos_hi    = 19;
   localparam int cmd_prot_lo   = 20;
   localparam int cmd_prot_hi   = 21;
   localparam int cmd_eom_bit   = 22;
   localparam int cmd_eof_bit   = 23;
   localparam int cmd_ex_bit    = 24;
   localparam int cmd_user_lo   = 25;
   localparam int cmd_user_hi   = 26;
   localparam int cmd_hostid_lo = 27;
   localparam int cmd_hostid_hi = 31;

   //########################################
   // Types
   //########################################
   typedef logic [umi_cw-1:0]  umi_cmd_word_t;
   typedef logic [umi_aw-1:0]  umi_addr_t;
   typedef logic [umi_idw-1:0] umi_in_data_t;
   typedef logic [umi_odw-1:0] umi_out_data_t;
   // LEN counts units minus one
   typedef logic [7:0]         umi_len_t;
   // One unit is 2**SIZE bytes
   typedef logic [2:0]         umi_size_t;
   typedef logic [fifo_aw-1:0] fifo_ptr_t;
   typedef logic [fifo_aw:0]   fifo_cnt_t;

   // Unpacked command fields
   typedef struct packed {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      umi_len_t   len;
      umi_size_t  size;
      logic [4:0] opcode;
   } umi_cmd_t;

   // One output beat as it travels to the ports
   typedef struct packed {
      umi_cmd_word_t cmd;
      umi_addr_t     dstaddr;
      umi_addr_t     srcaddr;
      umi_out_data_t data;
   } umi_beat_t;

   // Rebuild a raw command word from its fields
   function automatic umi_cmd_word_t pack_cmd(input umi_cmd_t c);
      umi_cmd_word_t w;
      w = '0;
      w[cmd_opcode_hi:cmd_opcode_lo] = c.opcode;
      w[cmd_size_hi:cmd_size_lo]     = c.size;
      w[cmd_len_hi:cmd_len_lo]       = c.len;
      w[cmd_qos_hi:cmd_qos_lo]       = c.qos;
      w[cmd_prot_hi:cmd_prot_lo]     = c.prot;
      w[cmd_eom_bit]                 = c.eom;
      w[cmd_eof_bit]                 = c.eof;
      w[cmd_ex_bit]                  = c.ex;
      w[cmd_user_hi:cmd_user_lo]     = c.user;
      w[cmd_hostid_hi:cmd_hostid_lo] = c.hostid;
      return w;
   endfunction

endpackage

// ==== design/umi_split_engine.sv ====
//########################################
// Split engine for the width adapter.
// Cuts transactions wider than one output
// beat into consecutive beats, holding the
// remainder in a latch between beats.
//########################################

module umi_split_engine
  (
   input  logic                        umi_in_clk,
   input  logic                        umi_in_nreset,
   // Input transaction
   input  logic                        in_valid,
   input  umi_flex_pkg::umi_cmd_word_t in_cmd,
   input  umi_flex_pkg::umi_addr_t     in_dstaddr,
   input  umi_flex_pkg::umi_addr_t     in_srcaddr,
   input  umi_flex_pkg::umi_in_data_t  in_data,
   output logic                        in_ready,
   // Decode loop
   output umi_flex_pkg::umi_cmd_word_t cur_cmd,
   input  umi_flex_pkg::umi_cmd_t      cmd,
   input  umi_flex_pkg::umi_len_t      beat_len,
   input  umi_flex_pkg::umi_len_t      rest_len,
   input  logic                        needs_split,
   // Beat out
   output umi_flex_pkg::umi_beat_t     beat,
   output logic                        beat_valid,
   input  logic                        beat_ready
   );

   import umi_flex_pkg::*;

   // Remainder latch
   logic          rem_valid;
   umi_cmd_word_t rem_cmd;
   umi_addr_t     rem_dstaddr;
   umi_addr_t     rem_srcaddr;
   umi_in_data_t  rem_data;

   // Current transaction from the latch or the input
   umi_addr_t     cur_dstaddr;
   umi_addr_t     cur_srcaddr;
   umi_in_data_t  cur_data;

   // Rewritten command fields
   umi_cmd_t      beat_fields;
   umi_cmd_t      rest_fields;
   logic          beat_fire;

   //########################################
   // Current selection
   //########################################
   assign cur_cmd     = rem_valid ? rem_cmd     : in_cmd;
   assign cur_dstaddr = rem_valid ? rem_dstaddr : in_dstaddr;
   assign cur_srcaddr = rem_valid ? rem_srcaddr : in_srcaddr;
   assign cur_data    = rem_valid ? rem_data    : in_data;

   //########################################
   // Command rewrite
   //########################################
   always_comb
   begin
      beat_fields     = cmd;
      beat_fields.len = beat_len;
      // EOM only travels with the last beat
      if (needs_split)
      begin
         beat_fields.eom = 1'b0;
      end
   end

   // Remainder keeps the original EOM
   always_comb
   begin
      rest_fields     = cmd;
      rest_fields.len = rest_len;
   end

   //########################################
   // Beat handshake
   //########################################
   assign beat.cmd     = pack_cmd(beat_fields);
   assign beat.dstaddr = cur_dstaddr;
   assign beat.srcaddr = cur_srcaddr;
   assign beat.data    = cur_data[umi_odw-1:0];

   assign beat_valid = rem_valid | in_valid;
   assign beat_fire  = beat_valid & beat_ready;

   // Input waits while a remainder is still draining
   assign in_ready = ~rem_valid & beat_ready;

   //########################################
   // Remainder latch
   //########################################
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         rem_valid <= 1'b0;
      end
      else if (beat_fire)
      begin
         rem_valid <= needs_split;
      end
   end

   // Payload advances by one output beat
   always_ff @(posedge umi_in_clk)
   begin
      if (beat_fire && needs_split)
      begin
         rem_cmd     <= pack_cmd(rest_fields);
         rem_dstaddr <= cur_dstaddr + umi_addr_t'(odw_bytes);
         rem_srcaddr <= cur_srcaddr + umi_addr_t'(odw_bytes);
         rem_data    <= cur_data >> umi_odw;
      end
   end

endmodule

// ==== design/umi_width_adapter.sv ====
//########################################
// UMI width adapter from a 128-bit input
// bus to a 64-bit output bus. Top level
// wiring of decode, split engine and FIFO.
//########################################

module umi_width_adapter
  (
   input  logic                         umi_in_clk,
   input  logic                         umi_in_nreset,
   // Control and status
   input  logic                         bypass,
   output logic                         fifo_full,
   output logic                         fifo_empty,
   // Input bus
   input  logic                         umi_in_valid,
   input  umi_flex_pkg::umi_cmd_word_t  umi_in_cmd,
   input  umi_flex_pkg::umi_addr_t      umi_in_dstaddr,
   input  umi_flex_pkg::umi_addr_t      umi_in_srcaddr,
   input  umi_flex_pkg::umi_in_data_t   umi_in_data,
   output logic                         umi_in_ready,
   // Output bus
   output logic                         umi_out_valid,
   output umi_flex_pkg::umi_cmd_word_t  umi_out_cmd,
   output umi_flex_pkg::umi_addr_t      umi_out_dstaddr,
   output umi_flex_pkg::umi_addr_t      umi_out_srcaddr,
   output umi_flex_pkg::umi_out_data_t  umi_out_data,
   input  logic                         umi_out_ready
   );

   import umi_flex_pkg::*;

   // Decode loop
   umi_cmd_word_t cur_cmd;
   umi_cmd_t      cmd;
   umi_len_t      beat_len;
   umi_len_t      rest_len;
   logic          needs_split;

   // Beat path
   umi_beat_t     beat;
   logic          beat_valid;
   logic          beat_ready;
   umi_beat_t     out_beat;

   umi_cmd_decode u_decode
     (.cur_cmd     (cur_cmd),
      .cmd         (cmd),
      .beat_len    (beat_len),
      .rest_len    (rest_len),
      .needs_split (needs_split));

   umi_split_engine u_split
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (umi_in_valid),
      .in_cmd        (umi_in_cmd),
      .in_dstaddr    (umi_in_dstaddr),
      .in_srcaddr    (umi_in_srcaddr),
      .in_data       (umi_in_data),
      .in_ready      (umi_in_ready),
      .cur_cmd       (cur_cmd),
      .cmd           (cmd),
      .beat_len      (beat_len),
      .rest_len      (rest_len),
      .needs_split   (needs_split),
      .beat          (beat),
      .beat_valid    (beat_valid),
      .beat_ready    (beat_ready));

   umi_beat_fifo u_fifo
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .bypass        (bypass),
      .beat          (beat),
      .beat_valid    (beat_valid),
      .beat_ready    (beat_ready),
      .out_beat      (out_beat),
      .out_valid     (umi_out_valid),
      .out_ready     (umi_out_ready),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty));

   // Beat fields onto the output ports
   assign umi_out_cmd     = out_beat.cmd;
   assign umi_out_dstaddr = out_beat.dstaddr;
   assign umi_out_srcaddr = out_beat.srcaddr;
   assign umi_out_data    = out_beat.data;

endmodule

// ==== list.f ====
design/umi_flex_pkg.sv
design/umi_cmd_decode.sv
design/umi_split_engine.sv
design/umi_beat_fifo.sv
design/umi_width_adapter.sv
test/umi_width_adapter_assertions.sv
test/tb_umi_width_adapter.sv

// ==== test/tb_umi_width_adapter.sv ====
//########################################
// Directed testbench for the UMI width
// adapter. Sends transactions, builds the
// expected output beats from the split
// rule and checks every beat that leaves.
//########################################

module tb_umi_width_adapter;

   timeunit 1ns;
   timeprecision 1ps;

   import umi_flex_pkg::*;

   localparam int timeout_cycles = 200;

   logic          umi_in_clk;
   logic          umi_in_nreset;
   logic          bypass;
   logic          fifo_full;
   logic          fifo_empty;
   logic          umi_in_valid;
   umi_cmd_word_t umi_in_cmd;
   umi_addr_t     umi_in_dstaddr;
   umi_addr_t     umi_in_srcaddr;
   umi_in_data_t  umi_in_data;
   logic          umi_in_ready;
   logic          umi_out_valid;
   umi_cmd_word_t umi_out_cmd;
   umi_addr_t     umi_out_dstaddr;
   umi_addr_t     umi_out_srcaddr;
   umi_out_data_t umi_out_data;
   logic          umi_out_ready;

   // Model of beats still owed by the DUT
   umi_beat_t   expected[$];
   umi_beat_t   exp_beat;
   int          errors = 0;
   string       test_name = "none";
   logic [31:0] rng_state = 32'h4ee;
   logic [31:0] stall_state = 32'h4ee;
   logic        stall_on = 1'b0;

   umi_width_adapter u_dut (.*);

   bind umi_width_adapter umi_width_adapter_assertions u_assertions
     (.umi_in_clk      (umi_in_clk),
      .umi_in_nreset   (umi_in_nreset),
      .umi_in_ready    (umi_in_ready),
      .umi_out_valid   (umi_out_valid),
      .umi_out_ready   (umi_out_ready),
      .umi_out_cmd     (umi_out_cmd),
      .umi_out_dstaddr (umi_out_dstaddr),
      .umi_out_srcaddr (umi_out_srcaddr),
      .umi_out_data    (umi_out_data));

   always #10 umi_in_clk = ~umi_in_clk;

   //########################################
   // Random numbers and command building
   //########################################
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // Fill bits land in the fields not set here and EOM is always set
   function automatic umi_cmd_word_t make_cmd(input umi_size_t size, input umi_len_t len,
                                              input logic [31:0] fill);
      umi_cmd_word_t w;
      w = fill;
      w[cmd_size_hi:cmd_size_lo] = size;
      w[cmd_len_hi:cmd_len_lo]   = len;
      w[cmd_eom_bit]             = 1'b1;
      return w;
   endfunction

   //########################################
   // Compare tasks
   //########################################
   task automatic check_cmd(input string name, input umi_cmd_word_t exp,
                            input umi_cmd_word_t act);
      if (act !== exp)
      begin
         errors++;
         $display("error: %s cmd expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input umi_addr_t exp, input umi_addr_t act);
      if (act !== exp)
      begin
         errors++;
         $display("error: %s addr expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input umi_out_data_t exp,
                             input umi_out_data_t act);
      if (act !== exp)
      begin
         errors++;
         $display("error: %s data expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         errors++;
         $display("error: %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout in test %s: %s", test_name, what);
      $display("errors: %0d", errors);
      $display("RESULT: FAIL");
      $finish;
   endtask

   //########################################
   // Split rule model
   //########################################
   task automatic push_expected(input umi_cmd_word_t cmd, input umi_addr_t dst,
                                input umi_addr_t src, input umi_in_data_t data);
      umi_beat_t b;
      int        units;
      int        cap;
      units = int'(cmd[cmd_len_hi:cmd_len_lo]) + 1;
      cap   = odw_bytes >> cmd[cmd_size_hi:cmd_size_lo];
      while (units > cap)
      begin
         b.cmd = cmd;
         b.cmd[cmd_len_hi:cmd_len_lo] = umi_len_t'(cap - 1);
         b.cmd[cmd_eom_bit] = 1'b0;
         b.dstaddr = dst;
         b.srcaddr = src;
         b.data    = data[umi_odw-1:0];
         expected.push_back(b);
         units = units - cap;
         dst   = dst + umi_addr_t'(odw_bytes);
         src   = src + umi_addr_t'(odw_bytes);
         data  = data >> umi_odw;
      end
      // Last beat keeps the original EOM
      b.cmd = cmd;
      b.cmd[cmd_len_hi:cmd_len_lo] = umi_len_t'(units - 1);
      b.dstaddr = dst;
      b.srcaddr = src;
      b.data    = data[umi_odw-1:0];
      expected.push_back(b);
   endtask

   //########################################
   // Stimulus tasks start at a falling edge
   //########################################
   task automatic send_txn(input umi_cmd_word_t cmd, input umi_addr_t dst,
                           input umi_addr_t src, input umi_in_data_t data);
      int   cycles;
      logic accepted;
      push_expected(cmd, dst, src, data);
      umi_in_valid   = 1'b1;
      umi_in_cmd     = cmd;
      umi_in_dstaddr = dst;
      umi_in_srcaddr = src;
      umi_in_data    = data;
      cycles   = 0;
      accepted = 1'b0;
      while (!accepted && cycles < timeout_cycles)
      begin
         @(posedge umi_in_clk);
         accepted = umi_in_ready;
         cycles++;
      end
      if (!accepted)
      begin
         fail_timeout("umi_in_ready never accepted the transaction");
      end
      @(negedge umi_in_clk);
      umi_in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (expected.size() != 0 && cycles < timeout_cycles)
      begin
         @(negedge umi_in_clk);
         cycles++;
      end
      if (expected.size() != 0)
      begin
         fail_timeout("expected beats never left the DUT");
      end
   endtask

   // Output monitor
   always @(posedge umi_in_clk)
   begin
      if (umi_in_nreset && umi_out_valid && umi_out_ready)
      begin
         if (expected.size() == 0)
         begin
            errors++;
            $display("output beat arrived with nothing expected in test %s", test_name);
         end
         else
         begin
            exp_beat = expected.pop_front();
            check_cmd(test_name, exp_beat.cmd, umi_out_cmd);
            check_addr({test_name, " dst"}, exp_beat.dstaddr, umi_out_dstaddr);
            check_addr({test_name, " src"}, exp_beat.srcaddr, umi_out_srcaddr);
            check_data(test_name, exp_beat.data, umi_out_data);
         end
      end
      if (umi_in_nreset && bypass && fifo_empty !== 1'b1)
      begin
         errors++;
         $display("fifo_empty went low while bypass was high in test %s", test_name);
      end
      if (umi_in_nreset && bypass && fifo_full !== ~umi_out_ready)
      begin
         errors++;
         $display("fifo_full did not follow umi_out_ready while bypass was high in test %s",
                  test_name);
      end
   end

   // Random back-pressure of about one stall in four
   always @(negedge umi_in_clk)
   begin
      if (stall_on)
      begin
         stall_state   = xorshift(stall_state);
         umi_out_ready = stall_state[3] | stall_state[9];
      end
   end

   //########################################
   // Tests
   //########################################
   task automatic test_reset();
      int i;
      test_name = "reset";
      for (i = 0; i < 4; i++)
      begin
         @(negedge umi_in_clk);
         check_bit("reset in_ready", 1'b0, umi_in_ready);
         check_bit("reset out_valid", 1'b0, umi_out_valid);
         check_bit("reset fifo_empty", 1'b1, fifo_empty);
         check_bit("reset fifo_full", 1'b0, fifo_full);
      end
      umi_in_nreset = 1'b1;
      check_bit("release edge 1 in_ready", 1'b0, umi_in_ready);
      @(negedge umi_in_clk);
      check_bit("release edge 2 in_ready", 1'b0, umi_in_ready);
      check_bit("release edge 2 out_valid", 1'b0, umi_out_valid);
      check_bit("release edge 2 fifo_empty", 1'b1, fifo_empty);
      check_bit("release edge 2 fifo_full", 1'b0, fifo_full);
      @(negedge umi_in_clk);
      check_bit("after release in_ready", 1'b1, umi_in_ready);
      check_bit("after release fifo_empty", 1'b1, fifo_empty);
      check_bit("after release fifo_full", 1'b0, fifo_full);
   endtask

   task automatic test_single();
      test_name = "single";
      send_txn(make_cmd(3'd3, 8'd0, 32'h2a41_0011), 64'h1000, 64'h8000_0000_2000,
               128'hdead_beef_0bad_f00d_0123_4567_89ab_cdef);
      send_txn(make_cmd(3'd0, 8'd7, 32'h9c30_0002), 64'h1238, 64'h40,
               128'h1111_2222_3333_4444_5555_6666_7777_8888);
      wait_drain();
   endtask

   task automatic test_split();
      test_name = "split";
      send_txn(make_cmd(3'd0, 8'd15, 32'h5a0c_3001), 64'h4000, 64'hffff_0000_0000_0100,
               128'hfedc_ba98_7654_3210_0f1e_2d3c_4b5a_6978);
      send_txn(make_cmd(3'd2, 8'd3, 32'h0f00_0004), 64'h7ff8, 64'h200,
               128'haaaa_bbbb_cccc_dddd_eeee_ffff_0000_1111);
      wait_drain();
   endtask

   task automatic test_backpressure();
      int cycles;
      test_name = "backpressure";
      umi_out_ready = 1'b0;
      send_txn(make_cmd(3'd1, 8'd7, 32'h0), 64'h100, 64'h900,
               128'h0001_0002_0003_0004_0005_0006_0007_0008);
      send_txn(make_cmd(3'd3, 8'd1, 32'h3), 64'h200, 64'ha00,
               128'h0009_000a_000b_000c_000d_000e_000f_0010);
      cycles = 0;
      while (!fifo_full && cycles < timeout_cycles)
      begin
         @(negedge umi_in_clk);
         cycles++;
      end
      if (!fifo_full)
      begin
         fail_timeout("fifo_full never rose with umi_out_ready low");
      end
      check_bit("backpressure in_ready", 1'b0, umi_in_ready);
      fork
         send_txn(make_cmd(3'd0, 8'd12, 32'h7), 64'h300, 64'hb00,
                  128'h0011_0012_0013_0014_0015_0016_0017_0018);
         begin
            repeat (3) @(negedge umi_in_clk);
            umi_out_ready = 1'b1;
         end
      join
      wait_drain();
   endtask

   task automatic test_bypass();
      test_name = "bypass";
      bypass = 1'b1;
      // One stalled cycle with nothing in flight
      umi_out_ready = 1'b0;
      @(negedge umi_in_clk);
      umi_out_ready = 1'b1;
      send_txn(make_cmd(3'd2, 8'd1, 32'h6200_0010), 64'h5000, 64'h6000,
               128'h1357_9bdf_2468_ace0_1122_3344_5566_7788);
      send_txn(make_cmd(3'd0, 8'd9, 32'h1b00_0003), 64'h5100, 64'h6100,
               128'h99aa_bbcc_ddee_ff00_0fed_cba9_8765_4321);
      wait_drain();
      bypass = 1'b0;
   endtask

   task automatic test_random();
      int            n;
      int            units;
      umi_size_t     size;
      umi_cmd_word_t cmd;
      umi_addr_t     dst;
      umi_addr_t     src;
      umi_in_data_t  data;
      test_name = "random";
      stall_on  = 1'b1;
      for (n = 0; n < 40; n++)
      begin
         size  = umi_size_t'(next_rand() % 32'd4);
         // At most 16 bytes per transaction
         units = int'(next_rand() % (32'd16 >> size)) + 1;
         cmd   = make_cmd(size, umi_len_t'(units - 1), next_rand());
         dst   = {next_rand(), next_rand()};
         src   = {next_rand(), next_rand()};
         data  = {next_rand(), next_rand(), next_rand(), next_rand()};
         send_txn(cmd, dst, src, data);
      end
      stall_on      = 1'b0;
      umi_out_ready = 1'b1;
      wait_drain();
   endtask

   initial
   begin
      umi_in_clk     = 1'b0;
      umi_in_nreset  = 1'b0;
      bypass         = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b1;
      test_reset();
      test_single();
      test_split();
      test_backpressure();
      test_bypass();
      test_random();
      errors = errors + u_dut.u_assertions.fail_count;
      $display("errors: %0d", errors);
      if (errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== test/umi_width_adapter_assertions.sv ====
//########################################
// Concurrent checks on the width adapter
// ports. Bound into umi_width_adapter by
// the testbench top.
//########################################

module umi_width_adapter_assertions
  (
   input logic                        umi_in_clk,
   input logic                        umi_in_nreset,
   input logic                        umi_in_ready,
   input logic                        umi_out_valid,
   input logic                        umi_out_ready,
   input umi_flex_pkg::umi_cmd_word_t umi_out_cmd,
   input umi_flex_pkg::umi_addr_t     umi_out_dstaddr,
   input umi_flex_pkg::umi_addr_t     umi_out_srcaddr,
   input umi_flex_pkg::umi_out_data_t umi_out_data
   );

   timeunit 1ns;
   timeprecision 1ps;

   import umi_flex_pkg::*;

   // Number of assertion failures so far
   int fail_count = 0;

   // Both ready and valid held low in reset and two edges after
   reset_quiet: assert property (@(posedge umi_in_clk)
      (!umi_in_nreset || !$past(umi_in_nreset) || !$past(umi_in_nreset, 2))
      |-> (!umi_in_ready && !umi_out_valid))
      else
      begin
         fail_count++;
         $error("umi_in_ready or umi_out_valid high too early after reset");
      end

   // Output beat held while stalled
   out_stable: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (umi_out_valid && !umi_out_ready)
      |=> (umi_out_valid && $stable(umi_out_cmd) && $stable(umi_out_dstaddr)
           && $stable(umi_out_srcaddr) && $stable(umi_out_data)))
      else
      begin
         fail_count++;
         $error("output beat changed while umi_out_ready was low");
      end

   // Beats without EOM are always full output beats
   eom_placement: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (umi_out_valid && !umi_out_cmd[cmd_eom_bit])
      |-> (umi_out_cmd[cmd_len_hi:cmd_len_lo]
           == umi_len_t'((odw_bytes >> umi_out_cmd[cmd_size_hi:cmd_size_lo]) - 1)))
      else
      begin
         fail_count++;
         $error("beat without EOM is not a full output beat");
      end

endmodule
